// ==== Bender.yml ====
package:
  name: riscv_single_cycle

sources:
  # RTL, package first
  - files:
      - hdl/riscvPkg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/regFile.sv
      - hdl/executeStage.sv
      - hdl/resultStage.sv
      - hdl/riscV.sv

  # testbench
  - target: test
    include_dirs:
      - sim
    files:
      - sim/riscvTb.sv

// ==== files.f ====
+incdir+sim
hdl/riscvPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/riscV.sv
sim/riscvTb.sv

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage
    import riscvPkg::*;
(
    input  instrWordU   instr,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] immExt,
    output logic [2:0]  aluCtrl,
    output logic        aluSrc,
    output logic        memWrite,
    output logic        resultSrc,
    output logic        regWrite,
    output logic        isBranch,
    output logic        branchOnNotEqual
);

    logic [1:0] immSel;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       isRType;

    // register fields sit at the same place in every format
    assign rs1      = instr.rType.rs1;
    assign rs2      = instr.rType.rs2;
    assign rd       = instr.rType.rd;
    assign opcode   = instr.rType.opcode;
    assign funct3   = instr.rType.funct3;
    assign funct7b5 = instr.rType.funct7[5];
    assign isRType  = (opcode == OP_RTYPE);

    // main decoder
    always_comb begin
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        resultSrc = 1'b0;
        isBranch  = 1'b0;
        immSel    = IMM_I;
        case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
            end
            OP_ITYPE: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = 1'b1;
            end
            OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSel   = IMM_S;
            end
            OP_BRANCH: begin
                isBranch = 1'b1;
                immSel   = IMM_B;
            end
            default: ;
        endcase
    end

    // beq is the fallback for any other branch funct3
    assign branchOnNotEqual = isBranch && (funct3 == F3_BNE);

    // alu decoder
    always_comb begin
        aluCtrl = ALU_ADD;
        if (isRType || opcode == OP_ITYPE) begin
            case (funct3)
                F3_ADD:  aluCtrl = (isRType && funct7b5) ? ALU_SUB : ALU_ADD;
                F3_SLT:  aluCtrl = ALU_SLT;
                F3_OR:   aluCtrl = ALU_OR;
                F3_AND:  aluCtrl = ALU_AND;
                default: aluCtrl = ALU_ADD;
            endcase
        end else if (isBranch) begin
            // compare by subtraction
            aluCtrl = ALU_SUB;
        end
    end

    // immediate extension
    always_comb begin
        case (immSel)
            IMM_S: immExt = {{20{instr.sType.immHi[6]}}, instr.sType.immHi,
                             instr.sType.immLo};
            IMM_B: immExt = {{20{instr.bType.imm12}}, instr.bType.imm11,
                             instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            default: immExt = {{20{instr.iType.imm[11]}}, instr.iType.imm};
        endcase
    end

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage
    import riscvPkg::*;
(
    input  logic [31:0] pc,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    input  logic [31:0] immExt,
    input  logic [2:0]  aluCtrl,
    input  logic        aluSrc,
    input  logic        isBranch,
    input  logic        branchOnNotEqual,
    output logic [31:0] aluResult,
    output logic        takeBranch,
    output logic [31:0] pcTarget
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic        zero;
    logic        lessThan;

    // operand select
    assign srcA = rd1;
    assign srcB = aluSrc ? immExt : rd2;

    // signed compare for slt/slti
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluCtrl)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_SLT: aluResult = {31'd0, lessThan};
            default: aluResult = srcA + srcB;
        endcase
    end

    assign zero = (aluResult == 32'd0);

    // beq takes on zero, bne on nonzero
    always_comb begin
        if (!isBranch) begin
            takeBranch = 1'b0;
        end else if (branchOnNotEqual) begin
            takeBranch = ~zero;
        end else begin
            takeBranch = zero;
        end
    end

    // branch target, pc relative
    assign pcTarget = pc + immExt;

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage
    import riscvPkg::*;
#(
    parameter int IMEM_ADDR_WIDTH = 5
)(
    input  logic                       CLK,
    input  logic                       rstN,
    input  logic                       takeBranch,
    input  logic [31:0]                pcTarget,
    input  logic                       progWe,
    input  logic [IMEM_ADDR_WIDTH-1:0] progAddr,
    input  logic [31:0]                progData,
    output logic [31:0]                pc,
    output instrWordU                  instr
);

    localparam int IMEM_DEPTH = 2 ** IMEM_ADDR_WIDTH;

    logic [31:0]                imem [IMEM_DEPTH];
    logic [31:0]                pcPlus4;
    logic [31:0]                pcNext;
    logic [IMEM_ADDR_WIDTH-1:0] fetchIndex;

    // program load port, independent of reset
    always_ff @(posedge CLK) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // word index, byte offset dropped
    assign fetchIndex = pc[IMEM_ADDR_WIDTH+1:2];
    assign instr      = imem[fetchIndex];

    // next pc select
    assign pcPlus4 = pc + 32'd4;
    assign pcNext  = takeBranch ? pcTarget : pcPlus4;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic        CLK,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        regWrite,
    input  logic [31:0] writeData,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] a0
);

    localparam logic [4:0] A0_INDEX = 5'd10;

    logic [31:0] regs [32];

    // x0 stays zero since it is cleared in reset and never written
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    // combinational read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // a0 tap
    assign a0 = regs[A0_INDEX];

endmodule

// ==== hdl/resultStage.sv ====
`timescale 1ns/1ps

module resultStage #(
    parameter int DMEM_ADDR_WIDTH = 6
)(
    input  logic        CLK,
    input  logic [31:0] aluResult,
    input  logic [31:0] storeData,
    input  logic        memWrite,
    input  logic        resultSrc,
    output logic [31:0] result
);

    localparam int DMEM_DEPTH = 2 ** DMEM_ADDR_WIDTH;

    logic [31:0]                dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_WIDTH-1:0] wordAddr;
    logic [31:0]                readData;

    // word access only, byte offset ignored
    assign wordAddr = aluResult[DMEM_ADDR_WIDTH+1:2];

    // stores land on the clock edge
    always_ff @(posedge CLK) begin
        if (memWrite) begin
            dmem[wordAddr] <= storeData;
        end
    end

    // loads read through without a clock
    assign readData = dmem[wordAddr];

    // writeback select
    assign result = resultSrc ? readData : aluResult;

endmodule

// ==== hdl/riscV.sv ====
`timescale 1ns/1ps

module riscV
    import riscvPkg::*;
#(
    parameter int IMEM_ADDR_WIDTH = 5,
    parameter int DMEM_ADDR_WIDTH = 6
)(
    input  logic                       CLK,
    input  logic                       rstN,
    input  logic                       progWe,
    input  logic [IMEM_ADDR_WIDTH-1:0] progAddr,
    input  logic [31:0]                progData,
    output logic [31:0]                a0
);

    // fetch
    logic [31:0] pc;
    instrWordU   instr;

    // decode
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] immExt;
    logic [2:0]  aluCtrl;
    logic        aluSrc;
    logic        memWrite;
    logic        resultSrc;
    logic        regWrite;
    logic        isBranch;
    logic        branchOnNotEqual;

    // register file and execute
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] aluResult;
    logic        takeBranch;
    logic [31:0] pcTarget;

    // writeback
    logic [31:0] result;
    logic        storeEnable;

    // stores held off while in reset
    assign storeEnable = memWrite & rstN;

    fetchStage #(
        .IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH)
    ) riscFetch (
        .CLK        (CLK),
        .rstN       (rstN),
        .takeBranch (takeBranch),
        .pcTarget   (pcTarget),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .pc         (pc),
        .instr      (instr)
    );

    decodeStage riscDecode (
        .instr            (instr),
        .rs1              (rs1),
        .rs2              (rs2),
        .rd               (rd),
        .immExt           (immExt),
        .aluCtrl          (aluCtrl),
        .aluSrc           (aluSrc),
        .memWrite         (memWrite),
        .resultSrc        (resultSrc),
        .regWrite         (regWrite),
        .isBranch         (isBranch),
        .branchOnNotEqual (branchOnNotEqual)
    );

    regFile riscRegFile (
        .CLK       (CLK),
        .rstN      (rstN),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .regWrite  (regWrite),
        .writeData (result),
        .rd1       (rd1),
        .rd2       (rd2),
        .a0        (a0)
    );

    executeStage riscExecute (
        .pc               (pc),
        .rd1              (rd1),
        .rd2              (rd2),
        .immExt           (immExt),
        .aluCtrl          (aluCtrl),
        .aluSrc           (aluSrc),
        .isBranch         (isBranch),
        .branchOnNotEqual (branchOnNotEqual),
        .aluResult        (aluResult),
        .takeBranch       (takeBranch),
        .pcTarget         (pcTarget)
    );

    resultStage #(
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) riscResult (
        .CLK       (CLK),
        .aluResult (aluResult),
        .storeData (rd2),
        .memWrite  (storeEnable),
        .resultSrc (resultSrc),
        .result    (result)
    );

endmodule

// ==== hdl/riscvPkg.sv ====
package riscvPkg;

    // major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 codes, arithmetic then branch and memory
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    // alu operations
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_AND = 3'b010;
    localparam logic [2:0] ALU_OR  = 3'b011;
    localparam logic [2:0] ALU_SLT = 3'b101;

    // immediate formats
    localparam logic [1:0] IMM_I = 2'b00;
    localparam logic [1:0] IMM_S = 2'b01;
    localparam logic [1:0] IMM_B = 2'b10;

    // one instruction word seen through each format
    typedef union packed {
        struct packed {
            logic [6:0]  funct7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0]  immHi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  immLo;
            logic [6:0]  opcode;
        } sType;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10to5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4to1;
            logic        imm11;
            logic [6:0]  opcode;
        } bType;
    } instrWordU;

endpackage

// ==== sim/riscvTests.svh ====
`ifndef RISCV_TESTS_SVH
`define RISCV_TESTS_SVH

localparam logic [4:0]  A0_REG  = 5'd10;
localparam logic [6:0]  F7_SUB  = 7'b0100000;
// funct3 for the add, sub, and, or and slt steps of registerArith
localparam logic [14:0] STEP_F3 = {F3_SLT, F3_OR, F3_AND, F3_ADD, F3_ADD};
// beq x0, x0, 0
localparam logic [31:0] HALT    = {7'd0, 5'd0, 5'd0, F3_BEQ, 5'd0, OP_BRANCH};

function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [2:0] f3);
    return {f7, rs2, rs1, f3, rd, OP_RTYPE};
endfunction

function automatic logic [31:0] immWord(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] addiWord(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return immWord(OP_ITYPE, rd, rs1, F3_ADD, imm);
endfunction

function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] branchWord(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

function automatic logic [11:0] randImm();
    return 12'($random(seed));
endfunction

task automatic immediateArith();
    logic [11:0] i1;
    logic [11:0] i2;
    logic [11:0] i3;
    logic [11:0] i4;
    logic [31:0] chain;
    logic [31:0] expected;
    startTest("immediateArith");
    i1 = randImm();
    i2 = randImm();
    i3 = randImm();
    i4 = randImm();
    prog.delete();
    prog.push_back(addiWord(5'd5, 5'd0, i1));
    prog.push_back(immWord(OP_ITYPE, 5'd6, 5'd5, F3_AND, i2));
    prog.push_back(immWord(OP_ITYPE, 5'd7, 5'd6, F3_OR, i3));
    prog.push_back(immWord(OP_ITYPE, 5'd8, 5'd7, F3_SLT, i4));
    prog.push_back(rTypeWord(7'd0, A0_REG, 5'd7, 5'd8, F3_ADD));
    prog.push_back(HALT);
    runProgram();
    chain    = (sext12(i1) & sext12(i2)) | sext12(i3);
    expected = chain + (($signed(chain) < $signed(sext12(i4))) ? 32'd1 : 32'd0);
    compareValue(expected, a0);
    finishTest();
endtask

task automatic registerArith();
    logic [11:0] x;
    logic [11:0] y;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] expected;
    startTest("registerArith");
    for (int step = 0; step < 5; step++) begin
        x   = randImm();
        y   = randImm();
        opA = sext12(x);
        opB = sext12(y);
        case (step)
            0: expected = opA + opB;
            1: expected = opA - opB;
            2: expected = opA & opB;
            3: expected = opA | opB;
            default: expected = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
        endcase
        prog.delete();
        prog.push_back(addiWord(5'd5, 5'd0, x));
        prog.push_back(addiWord(5'd6, 5'd0, y));
        prog.push_back(rTypeWord((step == 1) ? F7_SUB : 7'd0, A0_REG, 5'd5, 5'd6,
                                 STEP_F3[step*3 +: 3]));
        prog.push_back(HALT);
        runProgram();
        compareValue(expected, a0);
    end
    finishTest();
endtask

task automatic storeLoad();
    logic [11:0] addrA;
    logic [11:0] addrB;
    logic [11:0] valA;
    logic [11:0] valB;
    int          wordIdx;
    startTest("storeLoad");
    wordIdx = $random(seed) & ((1 << DMEM_ADDR_WIDTH) - 1);
    addrA   = 12'(wordIdx * 4);
    // neighbouring word
    addrB   = addrA ^ 12'h004;
    valA    = randImm();
    valB    = randImm();
    prog.delete();
    prog.push_back(addiWord(5'd5, 5'd0, addrA));
    prog.push_back(addiWord(5'd6, 5'd0, valA));
    prog.push_back(storeWord(5'd6, 5'd5, 12'd0));
    prog.push_back(immWord(OP_LOAD, A0_REG, 5'd5, F3_WORD, 12'd0));
    prog.push_back(HALT);
    runProgram();
    compareValue(sext12(valA), a0);
    // store elsewhere, then read back the first word
    prog.delete();
    prog.push_back(addiWord(5'd5, 5'd0, addrB));
    prog.push_back(addiWord(5'd6, 5'd0, valB));
    prog.push_back(storeWord(5'd6, 5'd5, 12'd0));
    prog.push_back(addiWord(5'd7, 5'd0, addrA));
    prog.push_back(immWord(OP_LOAD, A0_REG, 5'd7, F3_WORD, 12'd0));
    prog.push_back(HALT);
    runProgram();
    compareValue(sext12(valA), a0);
    prog.delete();
    prog.push_back(addiWord(5'd7, 5'd0, addrB));
    prog.push_back(immWord(OP_LOAD, A0_REG, 5'd7, F3_WORD, 12'd0));
    prog.push_back(HALT);
    runProgram();
    compareValue(sext12(valB), a0);
    finishTest();
endtask

task automatic branches();
    logic [11:0] x;
    logic [11:0] marker;
    logic [31:0] expected;
    logic        taken;
    startTest("branches");
    // bit 0 selects bne, bit 1 makes the operands differ
    for (int k = 0; k < 4; k++) begin
        x      = randImm();
        marker = randImm();
        prog.delete();
        prog.push_back(addiWord(5'd5, 5'd0, x));
        prog.push_back(addiWord(5'd6, 5'd0, k[1] ? (x ^ 12'h001) : x));
        prog.push_back(addiWord(A0_REG, 5'd0, marker));
        prog.push_back(branchWord(5'd5, 5'd6, k[0] ? F3_BNE : F3_BEQ, 13'd8));
        prog.push_back(addiWord(A0_REG, A0_REG, 12'h001));
        prog.push_back(HALT);
        runProgram();
        taken    = k[0] ? k[1] : !k[1];
        expected = sext12(marker) + (taken ? 32'd0 : 32'd1);
        compareValue(expected, a0);
    end
    finishTest();
endtask

task automatic zeroAndReset();
    logic [11:0] v;
    startTest("zeroAndReset");
    v = randImm() | 12'h001;
    // a write to x0 must not show up through a later read
    prog.delete();
    prog.push_back(addiWord(A0_REG, 5'd0, v));
    prog.push_back(addiWord(5'd0, 5'd0, v));
    prog.push_back(rTypeWord(7'd0, A0_REG, 5'd0, 5'd0, F3_ADD));
    prog.push_back(HALT);
    runProgram();
    compareValue(32'd0, a0);
    prog.delete();
    prog.push_back(addiWord(A0_REG, 5'd0, v));
    prog.push_back(HALT);
    runProgram();
    compareValue(sext12(v), a0);
    // reassert reset with the program left in place
    @(posedge CLK);
    rstN <= 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    compareValue(32'd0, a0);
    @(posedge CLK);
    releaseAndRun();
    compareValue(sext12(v), a0);
    finishTest();
endtask

`endif

// ==== sim/riscvTb.sv ====
`timescale 1ns/1ps

module riscvTb
    import riscvPkg::*;
();

    localparam int IMEM_ADDR_WIDTH = 5;
    localparam int DMEM_ADDR_WIDTH = 6;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int RUN_MARGIN      = 4;

    // watchdog budget, twice the expected length of all tests
    localparam int TEST_COUNT      = 5;
    localparam int CLOCKS_PER_TEST = 45;
    localparam int WATCHDOG_NS     = 2 * TEST_COUNT * CLOCKS_PER_TEST * CLK_PERIOD;

    logic                       CLK;
    logic                       rstN;
    logic                       progWe;
    logic [IMEM_ADDR_WIDTH-1:0] progAddr;
    logic [31:0]                progData;
    logic [31:0]                a0;

    logic [31:0] prog [$];
    integer      seed;
    string       curTest;
    int          testChecks;
    int          testErrors;
    int          passCount;
    int          errorCount;

    riscV #(
        .IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH),
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) dut0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    task automatic compareValue(input logic [31:0] expected, input logic [31:0] actual);
        testChecks++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("ERR %s expected %h actual %h", curTest, expected, actual);
        end else begin
            passCount++;
        end
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic finishTest();
        $display("%s finished: %0d checks, %0d mismatches", curTest, testChecks, testErrors);
    endtask

    // called right after a rising edge while reset is low
    task automatic releaseAndRun();
        rstN <= 1'b1;
        repeat (prog.size() + RUN_MARGIN) @(posedge CLK);
        @(negedge CLK);
    endtask

    // program goes in through the load port while the core sits in reset
    task automatic runProgram();
        @(posedge CLK);
        rstN <= 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            progWe   <= 1'b1;
            progAddr <= i[IMEM_ADDR_WIDTH-1:0];
            progData <= prog[i];
            @(posedge CLK);
        end
        progWe <= 1'b0;
        for (int i = prog.size(); i < RESET_CYCLES; i++) begin
            @(posedge CLK);
        end
        releaseAndRun();
    endtask

    `include "riscvTests.svh"

    initial begin
        seed       = 32'h73cd26d6;
        rstN       = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        passCount  = 0;
        errorCount = 0;
        repeat (RESET_CYCLES) @(posedge CLK);

        immediateArith();
        registerArith();
        storeLoad();
        branches();
        zeroAndReset();

        $display("summary: %0d checks passed, %0d errors", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
